/* Bender.yml */
package:
  name: rob_subsystem

sources:
  - include_dirs:
      - .
    files:
      - rob_pkg.sv
      - reorder_buffer.sv
      - commit_unit.sv
      - retire_map.sv
      - rob_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rob_subsystem.sv

/* commit_unit.sv */
`default_nettype none

`include "rob_macros.svh"

module commit_unit (
    input  wire                         clk,
    input  wire                         rst,
    input  wire rob_pkg::rob_entry_t    head_entry_0,
    input  wire rob_pkg::rob_entry_t    head_entry_1,
    input  wire                         head_finished_0,
    input  wire                         head_finished_1,
    input  wire [`ROB_IDX_W:0]          rob_count,
    output logic [1:0]                  retire_num,
    output logic                        commit_valid_0,
    output logic                        commit_valid_1,
    output logic [`ARCH_W-1:0]          commit_rd_arch_0,
    output logic [`ARCH_W-1:0]          commit_rd_arch_1,
    output logic [`PHY_W-1:0]           commit_rd_phy_0,
    output logic [`PHY_W-1:0]           commit_rd_phy_1,
    output logic [`PHY_W-1:0]           commit_rd_old_0,
    output logic [`PHY_W-1:0]           commit_rd_old_1,
    output logic                        commit_rd_we_0,
    output logic                        commit_rd_we_1,
    output logic                        commit_store_valid,
    output logic [`STORE_ID_W-1:0]      commit_store_id,
    output logic                        flush,
    output logic [`PC_W-1:0]            redirect_pc
);

    import rob_pkg::*;

    logic       ok_0;
    logic       ok_1;
    logic       mispred_0;
    logic       mispred_1;
    logic       store_0;
    logic       store_1;
    logic       take_2;
    logic       flush_next;
    rob_entry_t br_entry;

    assign ok_0 = head_finished_0 && (rob_count != '0);
    assign ok_1 = head_finished_1 && (rob_count > 1);

    assign mispred_0 = (head_entry_0.op_class == OP_BRANCH) &&
                       head_entry_0.result.branch.mispredict;
    assign mispred_1 = (head_entry_1.op_class == OP_BRANCH) &&
                       head_entry_1.result.branch.mispredict;
    assign store_0   = head_entry_0.op_class == OP_STORE;
    assign store_1   = head_entry_1.op_class == OP_STORE;

    // a mispredict ends the group; only one store port to report on
    assign take_2 = ok_0 && ok_1 && !mispred_0 && !(store_0 && store_1);

    assign retire_num = (flush || !ok_0) ? 2'd0 : (take_2 ? 2'd2 : 2'd1);

    assign flush_next = ((retire_num != 2'd0) && mispred_0) ||
                        ((retire_num == 2'd2) && mispred_1);
    assign br_entry   = mispred_0 ? head_entry_0 : head_entry_1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid_0     <= 1'b0;
            commit_valid_1     <= 1'b0;
            commit_store_valid <= 1'b0;
            flush              <= 1'b0;
        end else begin
            commit_valid_0     <= retire_num != 2'd0;
            commit_valid_1     <= retire_num == 2'd2;
            commit_store_valid <= ((retire_num != 2'd0) && store_0) ||
                                  ((retire_num == 2'd2) && store_1);
            flush              <= flush_next;
        end
    end

    always_ff @(posedge clk) begin
        commit_rd_arch_0 <= head_entry_0.rd_arch;
        commit_rd_arch_1 <= head_entry_1.rd_arch;
        commit_rd_phy_0  <= head_entry_0.rd_phy_new;
        commit_rd_phy_1  <= head_entry_1.rd_phy_new;
        commit_rd_old_0  <= head_entry_0.rd_phy_old;
        commit_rd_old_1  <= head_entry_1.rd_phy_old;
        commit_rd_we_0   <= head_entry_0.rd_we;
        commit_rd_we_1   <= head_entry_1.rd_we;
        commit_store_id  <= store_0 ? head_entry_0.result.store.store_id
                                    : head_entry_1.result.store.store_id;
        // not taken falls through to the next word
        redirect_pc      <= br_entry.result.branch.actual_taken
                          ? br_entry.result.branch.actual_target
                          : br_entry.pc + `PC_W'(4);
    end

    // a flush lasts one cycle and leaves the ROB empty behind it
    a_flush_single: assert property (@(posedge clk) disable iff (rst)
        flush |=> (!flush && (rob_count == '0)));

endmodule

`default_nettype wire

/* project.f */
+incdir+.
rob_pkg.sv
reorder_buffer.sv
commit_unit.sv
retire_map.sv
rob_subsystem.sv
tb_rob_subsystem.sv

/* reorder_buffer.sv */
`default_nettype none

`include "rob_macros.svh"

module reorder_buffer (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         flush,
    input  wire                         disp_valid_0,
    input  wire                         disp_valid_1,
    input  wire rob_pkg::rob_entry_t    disp_entry_0,
    input  wire rob_pkg::rob_entry_t    disp_entry_1,
    output logic [`ROB_IDX_W-1:0]       rob_id_0,
    output logic [`ROB_IDX_W-1:0]       rob_id_1,
    input  wire                         alu_wb_valid,
    input  wire [`ROB_IDX_W-1:0]        alu_wb_rob_id,
    input  wire                         load_wb_valid,
    input  wire [`ROB_IDX_W-1:0]        load_wb_rob_id,
    input  wire                         store_wb_valid,
    input  wire [`ROB_IDX_W-1:0]        store_wb_rob_id,
    input  wire [`STORE_ID_W-1:0]       store_wb_store_id,
    input  wire                         branch_wb_valid,
    input  wire [`ROB_IDX_W-1:0]        branch_wb_rob_id,
    input  wire [`PC_W-1:0]             branch_wb_target,
    input  wire                         branch_wb_taken,
    input  wire                         branch_wb_mispredict,
    input  wire [1:0]                   retire_num,
    output rob_pkg::rob_entry_t         head_entry_0,
    output rob_pkg::rob_entry_t         head_entry_1,
    output logic                        head_finished_0,
    output logic                        head_finished_1,
    output logic [`ROB_IDX_W:0]         rob_count,
    output logic                        rob_full
);

    import rob_pkg::*;

    rob_entry_t              rob_q [`ROB_ENTRIES];
    logic [`ROB_ENTRIES-1:0] finish_q;
    logic [`ROB_IDX_W-1:0]   head_q;
    logic [`ROB_IDX_W-1:0]   tail_q;
    logic [`ROB_IDX_W:0]     count_q;
    logic [`ROB_IDX_W-1:0]   head_plus1;
    logic [1:0]              alloc_num;

    // slot 1 alone takes the tail
    assign rob_id_0 = tail_q;
    assign rob_id_1 = disp_valid_0 ? tail_q + 1'b1 : tail_q;

    assign alloc_num  = {1'b0, disp_valid_0} + {1'b0, disp_valid_1};
    assign head_plus1 = head_q + 1'b1;

    assign head_entry_0    = rob_q[head_q];
    assign head_entry_1    = rob_q[head_plus1];
    assign head_finished_0 = finish_q[head_q];
    assign head_finished_1 = finish_q[head_plus1];
    assign rob_count       = count_q;
    // fewer than two free slots
    assign rob_full        = count_q > (`ROB_ENTRIES - 2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + {{(`ROB_IDX_W-2){1'b0}}, retire_num};
            tail_q  <= tail_q + {{(`ROB_IDX_W-2){1'b0}}, alloc_num};
            count_q <= count_q + {{(`ROB_IDX_W-1){1'b0}}, alloc_num}
                               - {{(`ROB_IDX_W-1){1'b0}}, retire_num};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            finish_q <= '0;
        end else if (flush) begin
            finish_q <= '0;
        end else begin
            // retired slots first, then new completions
            if (retire_num != 2'd0) begin
                finish_q[head_q] <= 1'b0;
            end
            if (retire_num == 2'd2) begin
                finish_q[head_plus1] <= 1'b0;
            end
            if (alu_wb_valid) begin
                finish_q[alu_wb_rob_id] <= 1'b1;
            end
            if (load_wb_valid) begin
                finish_q[load_wb_rob_id] <= 1'b1;
            end
            if (store_wb_valid) begin
                finish_q[store_wb_rob_id] <= 1'b1;
            end
            if (branch_wb_valid) begin
                finish_q[branch_wb_rob_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!flush) begin
            if (disp_valid_0) begin
                rob_q[rob_id_0] <= disp_entry_0;
            end
            if (disp_valid_1) begin
                rob_q[rob_id_1] <= disp_entry_1;
            end
        end
        if (store_wb_valid) begin
            rob_q[store_wb_rob_id].result.store.store_id <= store_wb_store_id;
        end
        if (branch_wb_valid) begin
            rob_q[branch_wb_rob_id].result.branch.actual_target <= branch_wb_target;
            rob_q[branch_wb_rob_id].result.branch.actual_taken  <= branch_wb_taken;
            rob_q[branch_wb_rob_id].result.branch.mispredict    <= branch_wb_mispredict;
        end
    end

    // index lies between head and tail
    function automatic logic is_live(input logic [`ROB_IDX_W-1:0] idx);
        logic [`ROB_IDX_W-1:0] offset;
        offset = idx - head_q;
        return {1'b0, offset} < count_q;
    endfunction

    a_no_disp_full: assert property (@(posedge clk) disable iff (rst)
        (rob_full || flush) |-> !(disp_valid_0 || disp_valid_1));

    a_wb_live: assert property (@(posedge clk) disable iff (rst)
        (!alu_wb_valid || is_live(alu_wb_rob_id)) &&
        (!load_wb_valid || is_live(load_wb_rob_id)) &&
        (!store_wb_valid || is_live(store_wb_rob_id)) &&
        (!branch_wb_valid || is_live(branch_wb_rob_id)));

    // commit unit must not retire past the first unfinished head entry
    a_retire_finished: assert property (@(posedge clk) disable iff (rst)
        retire_num <= ({1'b0, head_finished_0} +
                       {1'b0, head_finished_0 & head_finished_1}));

endmodule

`default_nettype wire

/* retire_map.sv */
`default_nettype none

`include "rob_macros.svh"

module retire_map (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 commit_valid_0,
    input  wire                 commit_valid_1,
    input  wire                 commit_rd_we_0,
    input  wire                 commit_rd_we_1,
    input  wire [`ARCH_W-1:0]   commit_rd_arch_0,
    input  wire [`ARCH_W-1:0]   commit_rd_arch_1,
    input  wire [`PHY_W-1:0]    commit_rd_phy_0,
    input  wire [`PHY_W-1:0]    commit_rd_phy_1,
    input  wire [`PHY_W-1:0]    commit_rd_old_0,
    input  wire [`PHY_W-1:0]    commit_rd_old_1,
    output logic                free_valid_0,
    output logic                free_valid_1,
    output logic [`PHY_W-1:0]   free_phy_0,
    output logic [`PHY_W-1:0]   free_phy_1,
    input  wire [`ARCH_W-1:0]   query_arch,
    output logic [`PHY_W-1:0]   query_phy
);

    logic [`PHY_W-1:0] map_q [2**`ARCH_W];

    assign query_phy = map_q[query_arch];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // identity mapping
            for (int i = 0; i < 2**`ARCH_W; i++) begin
                map_q[i] <= `PHY_W'(i);
            end
        end else begin
            // r0 stays hardwired; slot 1 written last so it wins
            if (commit_valid_0 && commit_rd_we_0 && (commit_rd_arch_0 != '0)) begin
                map_q[commit_rd_arch_0] <= commit_rd_phy_0;
            end
            if (commit_valid_1 && commit_rd_we_1 && (commit_rd_arch_1 != '0)) begin
                map_q[commit_rd_arch_1] <= commit_rd_phy_1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            free_valid_0 <= 1'b0;
            free_valid_1 <= 1'b0;
        end else begin
            free_valid_0 <= commit_valid_0 && commit_rd_we_0;
            free_valid_1 <= commit_valid_1 && commit_rd_we_1;
        end
    end

    always_ff @(posedge clk) begin
        free_phy_0 <= commit_rd_old_0;
        free_phy_1 <= commit_rd_old_1;
    end

endmodule

`default_nettype wire

/* rob_macros.svh */
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// ROB geometry
`define ROB_ENTRIES 16
`define ROB_IDX_W   4

// register tags
`define PHY_W       6
`define ARCH_W      5

// payload widths
`define PC_W        32
`define STORE_ID_W  4

`endif

/* rob_pkg.sv */
`default_nettype none

`include "rob_macros.svh"

package rob_pkg;

    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_BRANCH = 2'd3
    } op_class_e;

    typedef struct packed {
        logic [`PC_W-1:0] actual_target;
        logic             actual_taken;
        logic             mispredict;
    } branch_result_t;

    // store id sits in the low bits
    typedef struct packed {
        logic [`PC_W+2-`STORE_ID_W-1:0] pad;
        logic [`STORE_ID_W-1:0]         store_id;
    } store_result_t;

    typedef union packed {
        branch_result_t branch;
        store_result_t  store;
    } rob_result_u;

    typedef struct packed {
        logic [`ARCH_W-1:0] rd_arch;
        logic               rd_we;
        logic [`PHY_W-1:0]  rd_phy_old;
        logic [`PHY_W-1:0]  rd_phy_new;
        op_class_e          op_class;
        logic [`PC_W-1:0]   pc;
        rob_result_u        result;
    } rob_entry_t;

endpackage

`default_nettype wire

/* rob_subsystem.sv */
`default_nettype none

`include "rob_macros.svh"

module rob_subsystem (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         disp_valid_0,
    input  wire                         disp_valid_1,
    input  wire rob_pkg::rob_entry_t    disp_entry_0,
    input  wire rob_pkg::rob_entry_t    disp_entry_1,
    output logic [`ROB_IDX_W-1:0]       rob_id_0,
    output logic [`ROB_IDX_W-1:0]       rob_id_1,
    output logic                        rob_full,
    input  wire                         alu_wb_valid,
    input  wire [`ROB_IDX_W-1:0]        alu_wb_rob_id,
    input  wire                         load_wb_valid,
    input  wire [`ROB_IDX_W-1:0]        load_wb_rob_id,
    input  wire                         store_wb_valid,
    input  wire [`ROB_IDX_W-1:0]        store_wb_rob_id,
    input  wire [`STORE_ID_W-1:0]       store_wb_store_id,
    input  wire                         branch_wb_valid,
    input  wire [`ROB_IDX_W-1:0]        branch_wb_rob_id,
    input  wire [`PC_W-1:0]             branch_wb_target,
    input  wire                         branch_wb_taken,
    input  wire                         branch_wb_mispredict,
    output logic                        commit_valid_0,
    output logic                        commit_valid_1,
    output logic [`ARCH_W-1:0]          commit_rd_arch_0,
    output logic [`ARCH_W-1:0]          commit_rd_arch_1,
    output logic [`PHY_W-1:0]           commit_rd_phy_0,
    output logic [`PHY_W-1:0]           commit_rd_phy_1,
    output logic                        commit_rd_we_0,
    output logic                        commit_rd_we_1,
    output logic                        commit_store_valid,
    output logic [`STORE_ID_W-1:0]      commit_store_id,
    output logic                        flush,
    output logic [`PC_W-1:0]            redirect_pc,
    output logic                        free_valid_0,
    output logic                        free_valid_1,
    output logic [`PHY_W-1:0]           free_phy_0,
    output logic [`PHY_W-1:0]           free_phy_1,
    input  wire [`ARCH_W-1:0]           query_arch,
    output logic [`PHY_W-1:0]           query_phy
);

    import rob_pkg::*;

    rob_entry_t            head_entry_0;
    rob_entry_t            head_entry_1;
    logic                  head_finished_0;
    logic                  head_finished_1;
    logic [`ROB_IDX_W:0]   rob_count;
    logic [1:0]            retire_num;
    logic [`PHY_W-1:0]     commit_rd_old_0;
    logic [`PHY_W-1:0]     commit_rd_old_1;

    reorder_buffer u_rob (
        .clk, .rst, .flush,
        .disp_valid_0, .disp_valid_1, .disp_entry_0, .disp_entry_1,
        .rob_id_0, .rob_id_1,
        .alu_wb_valid, .alu_wb_rob_id,
        .load_wb_valid, .load_wb_rob_id,
        .store_wb_valid, .store_wb_rob_id, .store_wb_store_id,
        .branch_wb_valid, .branch_wb_rob_id, .branch_wb_target,
        .branch_wb_taken, .branch_wb_mispredict,
        .retire_num,
        .head_entry_0, .head_entry_1, .head_finished_0, .head_finished_1,
        .rob_count, .rob_full
    );

    commit_unit u_commit (
        .clk, .rst,
        .head_entry_0, .head_entry_1, .head_finished_0, .head_finished_1,
        .rob_count, .retire_num,
        .commit_valid_0, .commit_valid_1,
        .commit_rd_arch_0, .commit_rd_arch_1,
        .commit_rd_phy_0, .commit_rd_phy_1,
        .commit_rd_old_0, .commit_rd_old_1,
        .commit_rd_we_0, .commit_rd_we_1,
        .commit_store_valid, .commit_store_id,
        .flush, .redirect_pc
    );

    retire_map u_map (
        .clk, .rst,
        .commit_valid_0, .commit_valid_1,
        .commit_rd_we_0, .commit_rd_we_1,
        .commit_rd_arch_0, .commit_rd_arch_1,
        .commit_rd_phy_0, .commit_rd_phy_1,
        .commit_rd_old_0, .commit_rd_old_1,
        .free_valid_0, .free_valid_1, .free_phy_0, .free_phy_1,
        .query_arch, .query_phy
    );

endmodule

`default_nettype wire

/* tb_rob_model.svh */
// shadow ROB with the oldest entry at index 0
rob_entry_t            sh_entry[$];
logic [`ROB_IDX_W-1:0] sh_idx[$];
bit                    sh_done[$];
logic [`ROB_IDX_W-1:0] sh_tail;
logic [`PHY_W-1:0]     sh_map[2**`ARCH_W];

// expected registered outputs of the current cycle
rob_entry_t             exp_c0, exp_c1;
logic                   exp_cv0, exp_cv1, exp_sv, exp_flush, exp_fv0, exp_fv1;
logic [`STORE_ID_W-1:0] exp_sid;
logic [`PC_W-1:0]       exp_redirect;
logic [`PHY_W-1:0]      exp_fphy0, exp_fphy1;

function automatic bit is_mispredict(input rob_entry_t e);
    return (e.op_class == OP_BRANCH) && e.result.branch.mispredict;
endfunction

// pairs need both finished, no mispredict in slot 0 and one store at most
function automatic int expected_retire();
    int n;
    n = 0;
    if (!exp_flush && sh_done.size() > 0 && sh_done[0]) begin
        n = 1;
        if (sh_done.size() > 1 && sh_done[1] && !is_mispredict(sh_entry[0]) &&
            !(sh_entry[0].op_class == OP_STORE && sh_entry[1].op_class == OP_STORE)) begin
            n = 2;
        end
    end
    return n;
endfunction

function automatic logic [`PC_W-1:0] expected_redirect(input rob_entry_t e);
    return e.result.branch.actual_taken ? e.result.branch.actual_target : e.pc + 32'd4;
endfunction

task automatic model_reset();
    sh_entry.delete();
    sh_idx.delete();
    sh_done.delete();
    sh_tail = '0;
    for (int r = 0; r < 2**`ARCH_W; r++) begin
        sh_map[r] = `PHY_W'(r);
    end
    {exp_cv0, exp_cv1, exp_sv, exp_flush, exp_fv0, exp_fv1} = '0;
endtask

task automatic update_map(input logic valid, input rob_entry_t e);
    if (valid && e.rd_we && e.rd_arch != '0) begin
        sh_map[e.rd_arch] = e.rd_phy_new;
    end
endtask

// steps the model across the edge that ends this cycle
task automatic advance_model();
    int         n;
    bit         flushing;
    rob_entry_t e;
    n = expected_retire();
    flushing = exp_flush;
    exp_fv0 = exp_cv0 && exp_c0.rd_we;
    exp_fv1 = exp_cv1 && exp_c1.rd_we;
    exp_fphy0 = exp_c0.rd_phy_old;
    exp_fphy1 = exp_c1.rd_phy_old;
    update_map(exp_cv0, exp_c0);
    update_map(exp_cv1, exp_c1);
    exp_cv0 = n > 0;
    exp_cv1 = n > 1;
    exp_sv = 1'b0;
    exp_flush = 1'b0;
    for (int i = 0; i < n; i++) begin
        e = sh_entry.pop_front();
        sh_idx.delete(0);
        sh_done.delete(0);
        if (i == 0) begin
            exp_c0 = e;
        end else begin
            exp_c1 = e;
        end
        if (e.op_class == OP_STORE) begin
            exp_sv = 1'b1;
            exp_sid = e.result.store.store_id;
        end
        if (is_mispredict(e)) begin
            exp_flush = 1'b1;
            exp_redirect = expected_redirect(e);
        end
    end
    if (flushing) begin
        sh_entry.delete();
        sh_idx.delete();
        sh_done.delete();
        sh_tail = '0;
    end
endtask

task automatic model_dispatch(input rob_entry_t e);
    sh_entry.push_back(e);
    sh_idx.push_back(sh_tail);
    sh_done.push_back(1'b0);
    sh_tail = sh_tail + 1'b1;
endtask

// marks the entry finished and records its payload
task automatic model_writeback(input logic [`ROB_IDX_W-1:0] idx, input op_class_e cls);
    rob_entry_t e;
    foreach (sh_idx[k]) begin
        if (sh_idx[k] == idx) begin
            e = sh_entry[k];
            if (cls == OP_STORE) begin
                e.result.store.store_id = store_wb_store_id;
            end
            if (cls == OP_BRANCH) begin
                e.result.branch.actual_target = branch_wb_target;
                e.result.branch.actual_taken  = branch_wb_taken;
                e.result.branch.mispredict    = branch_wb_mispredict;
            end
            sh_entry[k] = e;
            sh_done[k] = 1'b1;
        end
    end
endtask

/* tb_rob_subsystem.sv */
`default_nettype none

`include "rob_macros.svh"

module tb_rob_subsystem;

    import rob_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_TXN      = 300;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + (NUM_TXN + 2**`ARCH_W) * 40;

    logic                   clk, rst;
    logic                   disp_valid_0, disp_valid_1;
    rob_entry_t             disp_entry_0, disp_entry_1;
    logic [`ROB_IDX_W-1:0]  rob_id_0, rob_id_1;
    logic                   rob_full;
    logic                   alu_wb_valid, load_wb_valid, store_wb_valid, branch_wb_valid;
    logic [`ROB_IDX_W-1:0]  alu_wb_rob_id, load_wb_rob_id, store_wb_rob_id, branch_wb_rob_id;
    logic [`STORE_ID_W-1:0] store_wb_store_id;
    logic [`PC_W-1:0]       branch_wb_target;
    logic                   branch_wb_taken, branch_wb_mispredict;
    logic                   commit_valid_0, commit_valid_1, commit_rd_we_0, commit_rd_we_1;
    logic [`ARCH_W-1:0]     commit_rd_arch_0, commit_rd_arch_1;
    logic [`PHY_W-1:0]      commit_rd_phy_0, commit_rd_phy_1;
    logic                   commit_store_valid;
    logic [`STORE_ID_W-1:0] commit_store_id;
    logic                   flush;
    logic [`PC_W-1:0]       redirect_pc;
    logic                   free_valid_0, free_valid_1;
    logic [`PHY_W-1:0]      free_phy_0, free_phy_1;
    logic [`ARCH_W-1:0]     query_arch;
    logic [`PHY_W-1:0]      query_phy;

    integer                 seed;
    int                     checks = 0;
    int                     errors = 0;
    int                     cycle_count = 0;
    int                     dispatched = 0;
    logic [`PC_W-1:0]       next_pc;
    // unfinished entries waiting for their writeback
    logic [`ROB_IDX_W-1:0]  pend_idx[$];
    op_class_e              pend_cls[$];

    `include "tb_rob_model.svh"

    rob_subsystem dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic rob_entry_t make_entry();
        rob_entry_t e;
        e = '0;
        e.rd_arch    = `ARCH_W'(rand_below(32));
        e.rd_we      = rand_below(4) != 0;
        e.rd_phy_old = `PHY_W'(rand_below(64));
        e.rd_phy_new = `PHY_W'(rand_below(64));
        case (rand_below(10))
            0, 1, 2, 3: e.op_class = OP_ALU;
            4, 5:       e.op_class = OP_LOAD;
            6, 7:       e.op_class = OP_STORE;
            default:    e.op_class = OP_BRANCH;
        endcase
        e.pc = next_pc;
        next_pc = next_pc + 32'd4;
        return e;
    endfunction

    function automatic int pick_pending(input op_class_e cls);
        int cand[$];
        foreach (pend_cls[k]) begin
            if (pend_cls[k] == cls) begin
                cand.push_back(k);
            end
        end
        if (cand.size() == 0) begin
            return -1;
        end
        return cand[rand_below(cand.size())];
    endfunction

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic clear_inputs();
        {disp_valid_0, disp_valid_1} = '0;
        {alu_wb_valid, load_wb_valid, store_wb_valid, branch_wb_valid} = '0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_cycle(input bit allow_disp);
        int                    pos;
        int                    rate;
        logic [1:0]            w;
        logic [`ROB_IDX_W-1:0] idx;
        clear_inputs();
        query_arch = `ARCH_W'(rand_below(32));
        if (flush) begin
            pend_idx.delete();
            pend_cls.delete();
            return;
        end
        // slow phases let the ROB fill up
        rate = (!allow_disp || (cycle_count / 64) % 2 == 1) ? 6 : 1;
        for (int c = 0; c < 4; c++) begin
            pos = pick_pending(op_class_e'(c));
            if (pos >= 0 && rand_below(8) < rate) begin
                idx = pend_idx[pos];
                pend_idx.delete(pos);
                pend_cls.delete(pos);
                case (op_class_e'(c))
                    OP_ALU: begin
                        alu_wb_valid  = 1'b1;
                        alu_wb_rob_id = idx;
                    end
                    OP_LOAD: begin
                        load_wb_valid  = 1'b1;
                        load_wb_rob_id = idx;
                    end
                    OP_STORE: begin
                        store_wb_valid    = 1'b1;
                        store_wb_rob_id   = idx;
                        store_wb_store_id = `STORE_ID_W'(rand_below(16));
                    end
                    default: begin
                        branch_wb_valid      = 1'b1;
                        branch_wb_rob_id     = idx;
                        branch_wb_target     = $random(seed) & 32'hffff_fffc;
                        branch_wb_taken      = rand_below(2) != 0;
                        branch_wb_mispredict = rand_below(6) == 0;
                    end
                endcase
            end
        end
        if (allow_disp && !rob_full) begin
            w = 2'(rand_below(4));
            if (w[0]) begin
                disp_valid_0 = 1'b1;
                disp_entry_0 = make_entry();
                pend_idx.push_back(sh_tail);
                pend_cls.push_back(disp_entry_0.op_class);
            end
            if (w[1]) begin
                disp_valid_1 = 1'b1;
                disp_entry_1 = make_entry();
                pend_idx.push_back(sh_tail + `ROB_IDX_W'(w[0]));
                pend_cls.push_back(disp_entry_1.op_class);
            end
            dispatched += w[0] + w[1];
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        seed = 92;
        next_pc = 32'h0000_1000;
        rst = 1'b1;
        clear_inputs();
        {disp_entry_0, disp_entry_1} = '0;
        {alu_wb_rob_id, load_wb_rob_id, store_wb_rob_id, branch_wb_rob_id} = '0;
        store_wb_store_id = '0;
        branch_wb_target = '0;
        {branch_wb_taken, branch_wb_mispredict} = '0;
        query_arch = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        // identity map after reset
        for (int r = 0; r < 2**`ARCH_W; r++) begin
            query_arch = `ARCH_W'(r);
            next_cycle();
        end
        while (dispatched < NUM_TXN) begin
            drive_cycle(1'b1);
            next_cycle();
        end
        while (pend_idx.size() != 0 || sh_idx.size() != 0) begin
            drive_cycle(1'b0);
            next_cycle();
        end
        clear_inputs();
        // last commit strobe and its free strobe
        repeat (3) next_cycle();
        finish_run();
    end

    always @(negedge clk) begin
        if (rst) begin
            model_reset();
        end else begin
            compare_value("commit_valid_0", commit_valid_0, exp_cv0);
            compare_value("commit_valid_1", commit_valid_1, exp_cv1);
            if (exp_cv0) begin
                compare_value("commit_rd_arch_0", commit_rd_arch_0, exp_c0.rd_arch);
                compare_value("commit_rd_phy_0", commit_rd_phy_0, exp_c0.rd_phy_new);
                compare_value("commit_rd_we_0", commit_rd_we_0, exp_c0.rd_we);
            end
            if (exp_cv1) begin
                compare_value("commit_rd_arch_1", commit_rd_arch_1, exp_c1.rd_arch);
                compare_value("commit_rd_phy_1", commit_rd_phy_1, exp_c1.rd_phy_new);
                compare_value("commit_rd_we_1", commit_rd_we_1, exp_c1.rd_we);
            end
            compare_value("commit_store_valid", commit_store_valid, exp_sv);
            if (exp_sv) begin
                compare_value("commit_store_id", commit_store_id, exp_sid);
            end
            compare_value("flush", flush, exp_flush);
            if (exp_flush) begin
                compare_value("redirect_pc", redirect_pc, exp_redirect);
            end
            compare_value("free_valid_0", free_valid_0, exp_fv0);
            compare_value("free_valid_1", free_valid_1, exp_fv1);
            if (exp_fv0) begin
                compare_value("free_phy_0", free_phy_0, exp_fphy0);
            end
            if (exp_fv1) begin
                compare_value("free_phy_1", free_phy_1, exp_fphy1);
            end
            compare_value("rob_full", rob_full, sh_idx.size() > `ROB_ENTRIES - 2);
            if (disp_valid_0) begin
                compare_value("rob_id_0", rob_id_0, sh_tail);
            end
            if (disp_valid_1) begin
                compare_value("rob_id_1", rob_id_1, `ROB_IDX_W'(sh_tail + disp_valid_0));
            end
            compare_value("query_phy", query_phy, sh_map[query_arch]);
            advance_model();
            if (alu_wb_valid) begin
                model_writeback(alu_wb_rob_id, OP_ALU);
            end
            if (load_wb_valid) begin
                model_writeback(load_wb_rob_id, OP_LOAD);
            end
            if (store_wb_valid) begin
                model_writeback(store_wb_rob_id, OP_STORE);
            end
            if (branch_wb_valid) begin
                model_writeback(branch_wb_rob_id, OP_BRANCH);
            end
            if (disp_valid_0) begin
                model_dispatch(disp_entry_0);
            end
            if (disp_valid_1) begin
                model_dispatch(disp_entry_1);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
            errors++;
            finish_run();
        end
    end

endmodule

`default_nettype wire
